/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = duckFlightTb
FILELIST = verilog.f
OBJDIR = obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* common/duckPkg.sv */
package duckPkg;

	// Field geometry
	localparam int coordW = 10;
	localparam int fieldXMax = 640;	// Right edge, left edge is 0
	localparam int fieldYMax = 460;	// Bottom edge, top edge is 0
	localparam int startY = 300;	// Y of every new duck
	localparam int parkX = 400;	// X held out of reset

	// Step magnitudes per fly tick
	localparam int stepLgX = 15;
	localparam int stepSmX = 12;
	localparam int stepLgY = 10;
	localparam int stepSmY = 2;

	localparam int legBase = 3;	// Added to NumRepeats for wing cycles per leg
	localparam int shockTicks = 16;	// Length of the hit pose

	typedef enum logic [2:0] {
		NW = 3'd0,
		W = 3'd1,
		NE = 3'd2,
		E = 3'd3,
		SW = 3'd4,
		SE = 3'd5
	} duckDir_t;

	// Encoding 3 is drawn as Black
	typedef enum logic [1:0] {
		Black = 2'd0,
		Red = 2'd1,
		Pink = 2'd2
	} duckColor_t;

	typedef enum logic [1:0] {
		Hidden = 2'd0,
		Flying = 2'd1,
		Hit = 2'd2
	} duckPose_t;

	typedef struct packed {
		logic [coordW-1:0] x;
		logic [coordW-1:0] y;
	} duckPos_t;

	// Sequencer to motion block
	typedef struct packed {
		logic spawn;	// Load start position and direction
		logic fly;	// One step
		logic redirect;	// Load newDir
		duckDir_t newDir;
	} duckCmd_t;

	// Base frame of the wing cycle, rows by direction, columns Black, Red, Pink
	localparam logic [0:5][0:2][5:0] flyBase = '{
		'{6'd11, 6'd31, 6'd51},	// NW
		'{6'd15, 6'd35, 6'd55},	// W
		'{6'd0, 6'd20, 6'd40},	// NE
		'{6'd4, 6'd24, 6'd44},	// E
		'{6'd11, 6'd31, 6'd51},	// SW
		'{6'd0, 6'd20, 6'd40}	// SE
	};

	// Shocked pose, one frame per facing side
	localparam logic [0:5][0:2][5:0] hitBase = '{
		'{6'd19, 6'd39, 6'd59},	// NW
		'{6'd19, 6'd39, 6'd59},	// W
		'{6'd8, 6'd28, 6'd48},	// NE
		'{6'd8, 6'd28, 6'd48},	// E
		'{6'd19, 6'd39, 6'd59},	// SW
		'{6'd8, 6'd28, 6'd48}	// SE
	};

endpackage

/* design/duckFlightTop.sv */
`timescale 1ns/100ps

module duckFlightTop import duckPkg::*; (
	input logic ANIM_Clk,
	input logic Reset,
	input logic Run,
	input logic DuckKill,
	input logic [1:0] ColorRand,
	input logic [1:0] DirRand,
	input logic [1:0] NumRepeats,
	input logic [coordW-1:0] StartX,
	output duckPos_t DuckPos,
	output logic [5:0] DuckFrame,
	output duckColor_t DuckColor,
	output logic DuckVisible,
	output logic DuckBounce
);

	duckCmd_t cmd;
	duckPose_t pose;
	duckDir_t dir;
	logic [1:0] phase;

	duckSequencer sequencer (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.Run(Run),
		.DuckKill(DuckKill),
		.NumRepeats(NumRepeats),
		.DirRand(DirRand),
		.ColorRand(ColorRand),
		.Bounce(DuckBounce),
		.Cmd(cmd),
		.Pose(pose),
		.Phase(phase),
		.Color(DuckColor),
		.Visible(DuckVisible)
	);

	duckMotion motion (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.Cmd(cmd),
		.StartX(StartX),
		.Pos(DuckPos),
		.Dir(dir),
		.Bounce(DuckBounce)
	);

	duckSprite sprite (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.Pose(pose),
		.Dir(dir),
		.Color(DuckColor),
		.Phase(phase),
		.Frame(DuckFrame)
	);

endmodule

/* design/duckMotion.sv */
`timescale 1ns/100ps

module duckMotion import duckPkg::*; (
	input logic ANIM_Clk,
	input logic Reset,
	input duckCmd_t Cmd,
	input logic [coordW-1:0] StartX,
	output duckPos_t Pos,
	output duckDir_t Dir,
	output logic Bounce
);

	typedef logic signed [coordW+1:0] sCoord_t;	// Room for both overshoots

	sCoord_t stepX, stepY;
	sCoord_t rawX, rawY;	// Unclamped next position
	duckPos_t nextPos;
	logic clampX, clampY;
	logic edgeHit;
	logic [coordW-1:0] spawnX;

	// Reflection at the edge that was hit, Y picks between wall and ceiling/floor
	function automatic duckDir_t reflectDir(input duckDir_t d, input logic [coordW-1:0] y);
		case (d)
			W: reflectDir = (y == '0) ? SW : E;
			E: reflectDir = (y == '0) ? SE : W;
			NW: reflectDir = (y == '0) ? SW : NE;
			NE: reflectDir = (y == '0) ? SE : NW;
			SW: reflectDir = (y == coordW'(fieldYMax)) ? NW : SE;
			SE: reflectDir = (y == coordW'(fieldYMax)) ? NE : SW;
			default: reflectDir = d;
		endcase
	endfunction

	always_comb
	begin
		stepX = '0;
		stepY = '0;
		case (Dir)
			NW:
			begin
				stepX = sCoord_t'(-stepSmX);
				stepY = sCoord_t'(-stepLgY);
			end
			W:
			begin
				stepX = sCoord_t'(-stepLgX);
				stepY = sCoord_t'(-stepSmY);
			end
			NE:
			begin
				stepX = sCoord_t'(stepSmX);
				stepY = sCoord_t'(-stepLgY);
			end
			E:
			begin
				stepX = sCoord_t'(stepLgX);
				stepY = sCoord_t'(-stepSmY);
			end
			SW:
			begin
				stepX = sCoord_t'(-stepSmX);
				stepY = sCoord_t'(stepLgY);
			end
			SE:
			begin
				stepX = sCoord_t'(stepSmX);
				stepY = sCoord_t'(stepLgY);
			end
			default: ;	// Unused codes stand still
		endcase
	end

	always_comb
	begin
		rawX = sCoord_t'(Pos.x) + stepX;
		rawY = sCoord_t'(Pos.y) + stepY;
		clampX = (rawX < 0) || (rawX > sCoord_t'(fieldXMax));
		clampY = (rawY < 0) || (rawY > sCoord_t'(fieldYMax));
		nextPos.x = (rawX < 0) ? '0 : clampX ? coordW'(fieldXMax) : rawX[coordW-1:0];
		nextPos.y = (rawY < 0) ? '0 : clampY ? coordW'(fieldYMax) : rawY[coordW-1:0];
		edgeHit = clampX | clampY;
		spawnX = (StartX > coordW'(fieldXMax)) ? coordW'(fieldXMax) : StartX;
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			Pos.x <= coordW'(parkX);
			Pos.y <= coordW'(startY);
			Dir <= NW;
			Bounce <= 1'b0;
		end
		else
		begin
			Bounce <= 1'b0;
			if (Cmd.spawn)
			begin
				Pos.x <= spawnX;
				Pos.y <= coordW'(startY);
				Dir <= Cmd.newDir;
			end
			else if (Cmd.fly)
			begin
				Pos <= nextPos;
				if (edgeHit)
				begin
					Dir <= reflectDir(Dir, nextPos.y);	// Uses the clamped Y
					Bounce <= 1'b1;
				end
			end
			else if (Cmd.redirect)
				Dir <= Cmd.newDir;
		end
	end

	assert property (@(posedge ANIM_Clk) disable iff (Reset)
		(Pos.x <= coordW'(fieldXMax)) && (Pos.y <= coordW'(fieldYMax)))
		else $error("duck left the field at x=%0d y=%0d", Pos.x, Pos.y);

	// A bounce pulse only comes out of a step
	assert property (@(posedge ANIM_Clk) disable iff (Reset) Bounce |-> $past(Cmd.fly))
		else $error("bounce without a fly command");

endmodule

/* design/duckSequencer.sv */
`timescale 1ns/100ps

module duckSequencer import duckPkg::*; (
	input logic ANIM_Clk,
	input logic Reset,
	input logic Run,
	input logic DuckKill,
	input logic [1:0] NumRepeats,
	input logic [1:0] DirRand,
	input logic [1:0] ColorRand,
	input logic Bounce,
	output duckCmd_t Cmd,
	output duckPose_t Pose,
	output logic [1:0] Phase,
	output duckColor_t Color,
	output logic Visible
);

	typedef enum logic [3:0] {
		stIdle,
		stSpawn,
		stAim,
		stFly1,
		stFly2,
		stFly3,
		stFly4,
		stBounce,
		stHit
	} seqState_t;

	seqState_t currState, nextState;
	logic [2:0] legCnt;	// Completed wing cycles in this leg
	logic [3:0] shockCnt;
	logic [2:0] legTarget;
	logic flying;
	logic legDone;

	assign legTarget = {1'b0, NumRepeats} + 3'(legBase);
	assign flying = currState inside {stFly1, stFly2, stFly3, stFly4};
	assign legDone = (legCnt + 3'd1) == legTarget;	// This Fly4 closes the last cycle
	assign Visible = (currState != stIdle);

	always_comb
	begin
		nextState = currState;
		case (currState)
			stIdle:
				if (Run)
					nextState = stSpawn;
			stSpawn:
				nextState = stAim;
			stAim:
				nextState = stFly1;
			stFly1, stFly2, stFly3, stFly4:
			begin
				if (DuckKill)
					nextState = stHit;
				else if (Bounce)
					nextState = stBounce;
				else if (currState == stFly4)
					nextState = legDone ? stAim : stFly1;
				else
					nextState = seqState_t'(currState + 4'd1);
			end
			stBounce:
				nextState = stFly1;
			stHit:
				if (shockCnt == 4'(shockTicks - 1))
					nextState = stSpawn;
			default:
				nextState = stIdle;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			currState <= stIdle;
			legCnt <= '0;
			shockCnt <= '0;
			Color <= Black;
		end
		else
		begin
			currState <= nextState;
			case (currState)
				stSpawn, stAim, stBounce:
					legCnt <= '0;
				stFly4:
					legCnt <= legCnt + 3'd1;
				default: ;
			endcase
			if (currState == stHit)
				shockCnt <= shockCnt + 4'd1;	// Wraps to 0 on the last hit tick
			if (currState == stSpawn)
				Color <= duckColor_t'(ColorRand);
		end
	end

	always_comb
	begin
		Cmd.spawn = (currState == stSpawn);
		Cmd.fly = flying;
		Cmd.redirect = (currState == stAim) && (legCnt != 3'd0);	// Only after a full leg
		Cmd.newDir = duckDir_t'({1'b0, DirRand});	// NW, W, NE, E
	end

	always_comb
	begin
		case (currState)
			stFly2: Phase = 2'd1;
			stFly3: Phase = 2'd2;
			stFly4: Phase = 2'd3;
			default: Phase = 2'd0;
		endcase
		case (currState)
			stIdle: Pose = Hidden;
			stHit: Pose = Hit;
			default: Pose = Flying;
		endcase
	end

	// Start and step never share a tick, the motion block would drop one
	assert property (@(posedge ANIM_Clk) disable iff (Reset) !(Cmd.spawn && Cmd.fly))
		else $error("spawn and fly issued together");

endmodule

/* design/duckSprite.sv */
`timescale 1ns/100ps

module duckSprite import duckPkg::*; (
	input logic ANIM_Clk,
	input logic Reset,
	input duckPose_t Pose,
	input duckDir_t Dir,
	input duckColor_t Color,
	input logic [1:0] Phase,
	output logic [5:0] Frame
);

	logic [2:0] dirIdx;
	logic [1:0] colIdx;
	logic [5:0] nextFrame;

	always_comb
	begin
		dirIdx = (Dir > SE) ? 3'd0 : Dir;	// Stray codes fall back to NW
		case (Color)
			Red: colIdx = 2'd1;
			Pink: colIdx = 2'd2;
			default: colIdx = 2'd0;	// Black, also code 3
		endcase
		case (Pose)
			Flying: nextFrame = flyBase[dirIdx][colIdx] + {4'd0, Phase};
			Hit: nextFrame = hitBase[dirIdx][colIdx];
			default: nextFrame = 6'd0;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
			Frame <= 6'd0;
		else
			Frame <= nextFrame;	// One tick behind pose and phase
	end

	// Sprite sheet ends at frame 59
	assert property (@(posedge ANIM_Clk) disable iff (Reset) Frame <= 6'd59)
		else $error("frame %0d past the sprite sheet", Frame);

endmodule

/* testbench/duckFlightTb.sv */
`timescale 1ns/100ps

module duckFlightTb import duckPkg::*; ();

	localparam int periodNs = 100;
	localparam int resetCycles = 3;
	localparam int idleTicks = 5;
	localparam int dirTicks = 80;	// Hit pose, respawn and the trip to the aimed edge
	localparam int killWaitTicks = 8;
	localparam int randTicks = 600;
	localparam int plannedTicks = resetCycles + idleTicks + 3 * dirTicks
		+ 2 * killWaitTicks + randTicks + 2;
	localparam int watchdogTicks = plannedTicks + 200;

	// Model states in flight order
	localparam logic [3:0] sIdle = 4'd0;
	localparam logic [3:0] sSpawn = 4'd1;
	localparam logic [3:0] sAim = 4'd2;
	localparam logic [3:0] sFly1 = 4'd3;
	localparam logic [3:0] sFly4 = 4'd6;
	localparam logic [3:0] sBounce = 4'd7;
	localparam logic [3:0] sHit = 4'd8;

	typedef struct packed {
		logic [3:0] st;
		logic [2:0] legCnt;
		logic [3:0] shockCnt;
		duckColor_t color;
		logic [coordW-1:0] x;
		logic [coordW-1:0] y;
		duckDir_t dir;
		logic bounce;
		logic [5:0] frame;
	} refModel_t;

	logic ANIM_Clk;
	logic Reset;
	logic Run;
	logic DuckKill;
	logic [1:0] ColorRand;
	logic [1:0] DirRand;
	logic [1:0] NumRepeats;
	logic [coordW-1:0] StartX;
	duckPos_t DuckPos;
	logic [5:0] DuckFrame;
	duckColor_t DuckColor;
	logic DuckVisible;
	logic DuckBounce;

	refModel_t model;
	logic [3:0] prevSt;
	int leftHits, rightHits, topHits, legEnds;

	duckFlightTop uut (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.Run(Run),
		.DuckKill(DuckKill),
		.ColorRand(ColorRand),
		.DirRand(DirRand),
		.NumRepeats(NumRepeats),
		.StartX(StartX),
		.DuckPos(DuckPos),
		.DuckFrame(DuckFrame),
		.DuckColor(DuckColor),
		.DuckVisible(DuckVisible),
		.DuckBounce(DuckBounce)
	);

	always #(periodNs / 2) ANIM_Clk = ~ANIM_Clk;

	function automatic refModel_t resetModel();
		refModel_t m;
		m = '0;
		m.st = sIdle;
		m.x = coordW'(400);
		m.y = coordW'(startY);
		m.dir = NW;
		return m;
	endfunction

	function automatic duckDir_t reflectOf(input duckDir_t d, input logic [coordW-1:0] y);
		case (d)
			W: return (y == '0) ? SW : E;
			E: return (y == '0) ? SE : W;
			NW: return (y == '0) ? SW : NE;
			NE: return (y == '0) ? SE : NW;
			SW: return (y == coordW'(fieldYMax)) ? NW : SE;
			default: return (y == coordW'(fieldYMax)) ? NE : SW;
		endcase
	endfunction

	// Sprite sheet rows step by 20 frames per color
	function automatic logic [5:0] frameOf(input logic [3:0] st, input duckDir_t d,
		input duckColor_t c);
		int colOfs;
		int base;
		logic westward;
		colOfs = (c == Red) ? 20 : (c == Pink) ? 40 : 0;
		westward = (d == NW) || (d == W) || (d == SW);
		if (st == sIdle)
			base = 0;
		else if (st == sHit)
			base = (westward ? 19 : 8) + colOfs;
		else
		begin
			base = (d == W) ? 15 : (d == E) ? 4 : westward ? 11 : 0;
			base = base + colOfs;
			if (st >= sFly1 && st <= sFly4)
				base = base + int'(st - sFly1);	// Wing phase
		end
		return 6'(base);
	endfunction

	function automatic refModel_t refStep(input refModel_t m, input logic run, input logic kill,
		input logic [1:0] colorRand, input logic [1:0] dirRand, input logic [1:0] numRep,
		input logic [coordW-1:0] startX);
		refModel_t n;
		int sx, sy, rx, ry;
		logic [2:0] legLen;
		n = m;
		n.bounce = 1'b0;
		n.frame = frameOf(m.st, m.dir, m.color);
		legLen = {1'b0, numRep} + 3'(legBase);
		case (m.st)
			sIdle:
				if (run)
					n.st = sSpawn;
			sSpawn:
			begin
				n.st = sAim;
				n.legCnt = '0;
				n.color = duckColor_t'(colorRand);
				n.x = (startX > coordW'(fieldXMax)) ? coordW'(fieldXMax) : startX;
				n.y = coordW'(startY);
				n.dir = duckDir_t'({1'b0, dirRand});
			end
			sAim:
			begin
				n.st = sFly1;
				if (m.legCnt != '0)
					n.dir = duckDir_t'({1'b0, dirRand});	// Leg finished
				n.legCnt = '0;
			end
			sBounce:
			begin
				n.st = sFly1;
				n.legCnt = '0;
			end
			sHit:
			begin
				n.shockCnt = m.shockCnt + 4'd1;
				if (m.shockCnt == 4'(shockTicks - 1))
					n.st = sSpawn;
			end
			default:
			begin
				sx = (m.dir == W || m.dir == E) ? stepLgX : stepSmX;
				if (m.dir == NW || m.dir == W || m.dir == SW)
					sx = -sx;
				sy = (m.dir == W || m.dir == E) ? -stepSmY :
					(m.dir == SW || m.dir == SE) ? stepLgY : -stepLgY;
				rx = int'(m.x) + sx;
				ry = int'(m.y) + sy;
				n.x = (rx < 0) ? '0 : (rx > fieldXMax) ? coordW'(fieldXMax) : coordW'(rx);
				n.y = (ry < 0) ? '0 : (ry > fieldYMax) ? coordW'(fieldYMax) : coordW'(ry);
				if (rx < 0 || rx > fieldXMax || ry < 0 || ry > fieldYMax)
				begin
					n.bounce = 1'b1;
					n.dir = reflectOf(m.dir, n.y);
				end
				if (m.st == sFly4)
					n.legCnt = m.legCnt + 3'd1;
				if (kill)
					n.st = sHit;
				else if (m.bounce)
					n.st = sBounce;
				else if (m.st == sFly4)
					n.st = (m.legCnt + 3'd1 == legLen) ? sAim : sFly1;
				else
					n.st = m.st + 4'd1;
			end
		endcase
		return n;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERR %s: got %h, expected %h", name, got, exp);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic aimDuck(input logic [1:0] dirCode, input logic [1:0] colorCode,
		input logic [coordW-1:0] x);
		DirRand = dirCode;
		ColorRand = colorCode;
		StartX = x;
	endtask

	// Kill the current duck so the next one spawns with new inputs
	task automatic newDuck(input logic [1:0] dirCode, input logic [1:0] colorCode,
		input logic [coordW-1:0] x);
		@(negedge ANIM_Clk);
		aimDuck(dirCode, colorCode, x);
		DuckKill = 1'b1;
		do
			@(negedge ANIM_Clk);
		while (model.st != sHit);
		DuckKill = 1'b0;
	endtask

	always
	begin
		@(posedge ANIM_Clk);
		prevSt = model.st;
		if (Reset)
			model = resetModel();
		else
			model = refStep(model, Run, DuckKill, ColorRand, DirRand, NumRepeats, StartX);
		if (model.bounce && model.x == '0)
			leftHits++;
		if (model.bounce && model.x == coordW'(fieldXMax))
			rightHits++;
		if (model.bounce && model.y == '0)
			topHits++;
		if (model.st == sAim && prevSt == sFly4)
			legEnds++;
		#1;	// DUT registers have settled
		assert (DuckPos == {model.x, model.y})
			else reportMismatch("DuckPos", 32'(DuckPos), 32'({model.x, model.y}));
		assert (DuckFrame == model.frame)
			else reportMismatch("DuckFrame", 32'(DuckFrame), 32'(model.frame));
		assert (DuckVisible == (model.st != sIdle))
			else reportMismatch("DuckVisible", 32'(DuckVisible), 32'(model.st != sIdle));
		assert (DuckBounce == model.bounce)
			else reportMismatch("DuckBounce", 32'(DuckBounce), 32'(model.bounce));
		assert (DuckColor == model.color)
			else reportMismatch("DuckColor", 32'(DuckColor), 32'(model.color));
	end

	initial
	begin
		#(watchdogTicks * periodNs);
		reportFailure("Timeout: the tests did not complete in the expected number of cycles");
	end

	initial
	begin
		ANIM_Clk = 1'b0;
		Reset = 1'b1;
		Run = 1'b0;
		DuckKill = 1'b0;
		ColorRand = '0;
		DirRand = '0;
		NumRepeats = '0;
		StartX = '0;
		model = resetModel();
		leftHits = 0;
		rightHits = 0;
		topHits = 0;
		legEnds = 0;
		void'($urandom(32'h9c4c));
		repeat (resetCycles) @(negedge ANIM_Clk);
		Reset = 1'b0;
		assert (DuckPos.x == coordW'(400) && DuckPos.y == coordW'(300) && DuckFrame == 6'd0
			&& !DuckVisible && !DuckBounce)
			else reportFailure("Duck is not parked at (400, 300) and hidden after reset");
		repeat (idleTicks) @(negedge ANIM_Clk);	// Run low keeps the duck hidden
		NumRepeats = 2'd3;
		aimDuck(2'd1, 2'd1, coordW'(100));	// West into the left edge
		Run = 1'b1;
		repeat (dirTicks) @(negedge ANIM_Clk);
		newDuck(2'd3, 2'd2, coordW'(500));	// East into the right edge
		repeat (dirTicks) @(negedge ANIM_Clk);
		newDuck(2'd2, 2'd3, coordW'(100));	// NE up to the top edge
		repeat (dirTicks) @(negedge ANIM_Clk);
		repeat (randTicks)
		begin
			@(negedge ANIM_Clk);
			DirRand = 2'($urandom_range(3, 0));
			ColorRand = 2'($urandom_range(3, 0));
			NumRepeats = 2'($urandom_range(3, 0));
			StartX = coordW'($urandom_range(fieldXMax, 0));
			DuckKill = ($urandom_range(39, 0) == 0);
		end
		@(negedge ANIM_Clk);
		DuckKill = 1'b0;
		@(negedge ANIM_Clk);
		assert (leftHits > 0) else reportFailure("The duck never bounced off the left edge");
		assert (rightHits > 0) else reportFailure("The duck never bounced off the right edge");
		assert (topHits > 0) else reportFailure("The duck never bounced off the top edge");
		assert (legEnds > 0) else reportFailure("No flight leg ever ran to its end");
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* verilog.f */
common/duckPkg.sv
design/duckSequencer.sv
design/duckMotion.sv
design/duckSprite.sv
design/duckFlightTop.sv
testbench/duckFlightTb.sv
